// ==== all.f ====
+incdir+common
common/pkt_pkg.sv
packet_assembler/packet_assembler.sv
verilog/packet_fifo.sv
verilog/packet_dispatch.sv
verilog/packet_manager_top.sv
sim/tb_packet_manager.sv

// ==== Bender.yml ====
package:
  name: packet_manager

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/pkt_pkg.sv
      - packet_assembler/packet_assembler.sv
      - verilog/packet_fifo.sv
      - verilog/packet_dispatch.sv
      - verilog/packet_manager_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - sim/tb_packet_manager.sv

// ==== sim/tb_packet_manager.sv ====
// packet manager testbench with stimulus table, queue reference model, output monitor and checks
`include "pkt_cfg.svh"

module tb_packet_manager;
	import pkt_pkg::*;

	localparam int M_GOOD     = 0;                          // full packet with correct checksum
	localparam int M_BAD      = 1;                          // full packet with corrupted last byte
	localparam int M_STALL    = 2;                          // k bytes then long pause then good packet
	localparam int A_HIGH     = 0;                          // packet_accept held high
	localparam int A_LOW      = 1;                          // held low for back-pressure
	localparam int A_TOGGLE   = 2;                          // random per cycle
	localparam int STALL_IDLE = `PKT_TIMEOUT_CYCLES + 8;    // pause well past the window
	localparam int WAIT_LIMIT = 400;                        // cycles any single wait may take
	localparam int NROWS      = 16;

	typedef struct {
		int mode; // M_*
		int k;    // bytes sent before a stall
		int gap;  // extra idle cycles between strobes
		int acc;  // A_*
		bit lat;  // measure last byte to packet_valid
	} row_t;

	// mode, k, gap, accept, latency
	row_t rows [NROWS] = '{
		'{M_GOOD,  0,  0, A_HIGH,   1'b1}, // first packet on an empty path
		'{M_GOOD,  0,  1, A_HIGH,   1'b0},
		'{M_BAD,   0,  0, A_HIGH,   1'b0},
		'{M_GOOD,  0,  2, A_TOGGLE, 1'b0},
		'{M_STALL, 5,  0, A_HIGH,   1'b0},
		'{M_BAD,   0,  1, A_TOGGLE, 1'b0},
		'{M_STALL, 15, 1, A_HIGH,   1'b0}, // stalls one byte short
		'{M_GOOD,  0,  0, A_LOW,    1'b0}, // fills output register
		'{M_GOOD,  0,  0, A_LOW,    1'b0},
		'{M_GOOD,  0,  1, A_LOW,    1'b0},
		'{M_BAD,   0,  1, A_LOW,    1'b0},
		'{M_GOOD,  0,  0, A_LOW,    1'b0}, // fifo now full
		'{M_GOOD,  0,  0, A_LOW,    1'b0}, // dropped
		'{M_GOOD,  0,  2, A_LOW,    1'b0}, // dropped
		'{M_GOOD,  0,  1, A_HIGH,   1'b0}, // release lets the backlog drain
		'{M_GOOD,  0,  0, A_HIGH,   1'b1}
	};

	logic               dataAvailable_in;
	logic               reset;
	logic               byte_valid;
	pkt_byte_t          data_in;
	logic               packet_accept;
	pkt_data_t          packet_out;
	logic               packet_valid;
	logic               checksum_error;
	logic               timeout;
	logic               overflow;

	pkt_data_t          exp_data [$];   // packets the model says will come out in order
	logic               exp_bad [$];    // matching checksum_error values
	logic [31:0]        data_seed;      // lcg state for payload bytes
	logic [31:0]        acc_seed;       // lcg state for accept toggling
	int                 acc_mode;       // accept pattern of the current row
	int                 timeouts_seen = 0;
	int                 overflows_seen = 0;
	int                 checks = 0;
	int                 mismatches = 0;
	int                 failures = 0;
	bit                 hold_check = 1'b0; // output was stalled at the last sample
	pkt_data_t          held_pkt;

	packet_manager_top u_packet_manager_top (
		.dataAvailable_in (dataAvailable_in),
		.reset            (reset),
		.byte_valid       (byte_valid),
		.data_in          (data_in),
		.packet_accept    (packet_accept),
		.packet_out       (packet_out),
		.packet_valid     (packet_valid),
		.checksum_error   (checksum_error),
		.timeout          (timeout),
		.overflow         (overflow)
	);

	always begin
		#2 dataAvailable_in = ~dataAvailable_in; // 4 unit period
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic pkt_byte_t next_byte();
		data_seed = lcg_next(data_seed);
		return data_seed[23:16]; // upper bits are the better ones
	endfunction

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		assert (got === exp) else begin
			mismatches++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_word(input string name, input pkt_data_t got, input pkt_data_t exp);
		checks++;
		assert (got === exp) else begin
			mismatches++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		assert (got == exp) else begin
			mismatches++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_quiet(input string when);
		check_bit({"packet_valid ", when}, packet_valid, 1'b0);
		check_bit({"timeout ", when}, timeout, 1'b0);
		check_bit({"overflow ", when}, overflow, 1'b0);
	endtask

	task automatic finish_run();
		$display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	endtask

	task automatic abort_wait(input string what);
		failures++;
		$display("Timeout: %s", what);
		finish_run();
	endtask

	// downstream side sampled mid-cycle where inputs and outputs are settled
	task automatic take_packet();
		checks++;
		assert (exp_data.size() != 0) else begin
			failures++;
			$display("Unexpected packet on packet_out: %h", packet_out);
		end
		if (exp_data.size() != 0) begin
			check_word("packet_out", packet_out, exp_data.pop_front());
			check_bit("checksum_error", checksum_error, exp_bad.pop_front());
		end
	endtask

	always @(negedge dataAvailable_in) begin
		if (!reset) begin
			timeouts_seen  = timeouts_seen + int'(timeout);
			overflows_seen = overflows_seen + int'(overflow);
			if (hold_check) begin
				check_bit("packet_valid while held", packet_valid, 1'b1);
				check_word("packet_out while held", packet_out, held_pkt);
			end
			hold_check = packet_valid && !packet_accept; // no transfer at the next edge
			held_pkt   = packet_out;
			if (packet_valid && packet_accept) begin
				take_packet();
			end
		end
	end

	always @(posedge dataAvailable_in) begin
		acc_seed <= lcg_next(acc_seed);
		case (acc_mode)
			A_LOW:    packet_accept <= 1'b0;
			A_TOGGLE: packet_accept <= acc_seed[20];
			default:  packet_accept <= 1'b1;
		endcase
	end

	task automatic send_byte(input pkt_byte_t b, input int gap);
		@(posedge dataAvailable_in);
		byte_valid <= 1'b1;
		data_in    <= b;
		@(posedge dataAvailable_in);
		byte_valid <= 1'b0;
		repeat (gap) @(posedge dataAvailable_in);
	endtask

	task automatic send_packet(input bit corrupt, input int gap, input bit lat, output int dropped);
		pkt_byte_t bytes [`PKT_BYTES];
		pkt_byte_t sum;
		pkt_data_t expect_pkt;
		int        cycles;
		sum        = '0;
		expect_pkt = '0;
		dropped    = 0;
		for (int i = 0; i < `PKT_BYTES - 1; i++) begin
			bytes[i] = next_byte();
			sum      = sum + bytes[i]; // mod 256
		end
		bytes[`PKT_BYTES-1] = corrupt ? (sum ^ 8'h5a) : sum;
		for (int i = 0; i < `PKT_BYTES; i++) begin
			expect_pkt = {expect_pkt[`PKT_BITS-9:0], bytes[i]}; // first byte ends on top
		end
		for (int i = 0; i < `PKT_BYTES - 1; i++) begin
			send_byte(bytes[i], gap);
		end
		// output register plus fifo hold depth+1 packets and any further push is lost
		if (exp_data.size() >= `PKT_FIFO_DEPTH + 1) begin
			dropped = 1;
		end else begin
			exp_data.push_back(expect_pkt);
			exp_bad.push_back(corrupt);
		end
		if (!lat) begin
			send_byte(bytes[`PKT_BYTES-1], gap);
		end else begin
			@(posedge dataAvailable_in);
			byte_valid <= 1'b1;
			data_in    <= bytes[`PKT_BYTES-1];
			cycles = 0;
			do begin
				@(posedge dataAvailable_in);
				byte_valid <= 1'b0;
				cycles++;
				@(negedge dataAvailable_in);
			end while (packet_valid !== 1'b1 && cycles < WAIT_LIMIT);
			if (cycles >= WAIT_LIMIT) begin
				abort_wait("packet_valid never rose after the sixteenth byte");
			end else begin
				check_count("cycles from last strobe to packet_valid", cycles, 3);
			end
		end
	endtask

	task automatic wait_drained(input int r);
		int cycles;
		cycles = 0;
		while (exp_data.size() != 0 && cycles < WAIT_LIMIT) begin
			@(posedge dataAvailable_in);
			cycles++;
		end
		if (exp_data.size() != 0) begin
			abort_wait($sformatf("row %0d, expected packets never left the DUT", r));
		end
	endtask

	task automatic run_row(input int r);
		int to_before;
		int ovf_before;
		int exp_to;
		int exp_ovf;
		to_before  = timeouts_seen;
		ovf_before = overflows_seen;
		exp_to     = 0;
		@(posedge dataAvailable_in);
		acc_mode <= rows[r].acc;
		if (rows[r].mode == M_STALL) begin
			for (int i = 0; i < rows[r].k; i++) begin
				send_byte(next_byte(), rows[r].gap);
			end
			repeat (STALL_IDLE) @(posedge dataAvailable_in);
			if (rows[r].k * (rows[r].gap + 2) + STALL_IDLE >= `PKT_TIMEOUT_CYCLES) begin
				exp_to = 1; // partial packet outlived its window
			end
		end
		send_packet(rows[r].mode == M_BAD, rows[r].gap, rows[r].lat, exp_ovf);
		if (rows[r].acc != A_LOW) begin
			wait_drained(r);
		end
		repeat (6) @(posedge dataAvailable_in); // let late pulses land
		check_count($sformatf("timeout pulses in row %0d", r), timeouts_seen - to_before, exp_to);
		check_count($sformatf("overflow pulses in row %0d", r), overflows_seen - ovf_before,
			exp_ovf);
	endtask

	initial begin
		dataAvailable_in = 1'b0;
		reset            = 1'b1;
		byte_valid       = 1'b0;
		data_in          = '0;
		packet_accept    = 1'b1;
		acc_mode         = A_HIGH;
		data_seed        = 32'h120f;
		acc_seed         = 32'h120f;
		repeat (10) begin
			@(negedge dataAvailable_in);
			check_quiet("during reset");
		end
		@(posedge dataAvailable_in);
		reset <= 1'b0;
		repeat (2) begin
			@(negedge dataAvailable_in);
			check_quiet("after reset");
		end
		for (int r = 0; r < NROWS; r++) begin
			run_row(r);
		end
		finish_run();
	end

endmodule

// ==== verilog/packet_manager_top.sv ====
// packet manager top level: assembler, packet fifo and dispatcher wired to plain ports
module packet_manager_top (
	input  logic               dataAvailable_in, // system clock
	input  logic               reset,            // sync, active high
	input  logic               byte_valid,       // one strobe per byte
	input  pkt_pkg::pkt_byte_t data_in,          // byte, valid with the strobe
	input  logic               packet_accept,    // downstream level
	output pkt_pkg::pkt_data_t packet_out,       // presented packet
	output logic               packet_valid,     // level while presented
	output logic               checksum_error,   // valid with packet_valid
	output logic               timeout,          // pulse, partial packet dropped
	output logic               overflow          // pulse, full buffer dropped a packet
);
	import pkt_pkg::*;

	pkt_data_t packet;      // assembler to fifo
	logic      packet_push; // assembler write strobe
	logic      fifo_full;   // fifo level back to assembler
	pkt_data_t head_packet; // fifo to dispatcher
	logic      nonempty;    // fifo has data
	logic      pop;         // dispatcher read strobe

	packet_assembler u_packet_assembler (
		.dataAvailable_in (dataAvailable_in),
		.reset            (reset),
		.byte_valid       (byte_valid),
		.data_in          (data_in),
		.fifo_full        (fifo_full),
		.packet           (packet),
		.packet_push      (packet_push),
		.timeout          (timeout)
	);

	packet_fifo u_packet_fifo (
		.dataAvailable_in (dataAvailable_in),
		.reset            (reset),
		.push             (packet_push),
		.push_packet      (packet),
		.pop              (pop),
		.head_packet      (head_packet),
		.nonempty         (nonempty),
		.full             (fifo_full),
		.overflow         (overflow)
	);

	packet_dispatch u_packet_dispatch (
		.dataAvailable_in (dataAvailable_in),
		.reset            (reset),
		.head_packet      (head_packet),
		.nonempty         (nonempty),
		.packet_accept    (packet_accept),
		.pop              (pop),
		.packet_out       (packet_out),
		.packet_valid     (packet_valid),
		.checksum_error   (checksum_error)
	);

endmodule

// ==== verilog/packet_dispatch.sv ====
// packet dispatch: pop control, held output register, byte-sum checksum check on load
`include "pkt_cfg.svh"

module packet_dispatch (
	input  logic               dataAvailable_in, // system clock
	input  logic               reset,            // sync, active high
	input  pkt_pkg::pkt_data_t head_packet,      // oldest buffered packet
	input  logic               nonempty,         // buffer holds a packet
	input  logic               packet_accept,    // downstream takes the output
	output logic               pop,              // strobe, head packet taken
	output pkt_pkg::pkt_data_t packet_out,       // presented packet
	output logic               packet_valid,     // level while presented
	output logic               checksum_error    // valid with packet_valid
);
	import pkt_pkg::*;

	pkt_byte_t byte_sum; // mod 256 sum of bytes 0 to 14
	logic      sum_bad;  // checksum byte disagrees

	// load when the register is free or being emptied this cycle
	assign pop = nonempty && (!packet_valid || packet_accept);

	// byte 0 is the top byte, byte 15 the bottom one holds the checksum
	always_comb begin
		byte_sum = '0;
		for (int i = 0; i < `PKT_BYTES - 1; i++) begin
			byte_sum = byte_sum + head_packet[(`PKT_BYTES - 1 - i) * 8 +: 8]; // wraps at 8 bits
		end
		sum_bad = (byte_sum != head_packet[7:0]);
	end

	// output payload, held until accepted
	always_ff @(posedge dataAvailable_in) begin
		if (pop) begin
			packet_out <= head_packet;
		end
	end

	always_ff @(posedge dataAvailable_in) begin
		if (reset) begin
			packet_valid   <= 1'b0;
			checksum_error <= 1'b0;
		end else if (pop) begin
			packet_valid   <= 1'b1;    // shows one cycle after the pop
			checksum_error <= sum_bad; // judged on load, travels with the packet
		end else if (packet_accept) begin
			packet_valid   <= 1'b0; // taken, nothing to replace it
		end
	end

	// back-pressure must freeze the presented packet
	a_hold_stable: assert property (
		@(posedge dataAvailable_in) disable iff (reset)
		(packet_valid && !packet_accept) |=> (packet_valid && $stable(packet_out))
	);

endmodule

// ==== verilog/packet_fifo.sv ====
// packet fifo: circular packet buffer with occupancy count, full/nonempty levels, overflow pulse
`include "pkt_cfg.svh"

module packet_fifo (
	input  logic               dataAvailable_in, // system clock
	input  logic               reset,            // sync, active high
	input  logic               push,             // write strobe from assembler
	input  pkt_pkg::pkt_data_t push_packet,      // packet to store
	input  logic               pop,              // read strobe from dispatcher
	output pkt_pkg::pkt_data_t head_packet,      // oldest packet, valid with nonempty
	output logic               nonempty,         // at least one packet held
	output logic               full,             // depth reached
	output logic               overflow          // pulse, a push was dropped
);
	import pkt_pkg::*;

	localparam int         PTR_W = (`PKT_FIFO_DEPTH > 1) ? $clog2(`PKT_FIFO_DEPTH) : 1;
	localparam pkt_level_t DEPTH = pkt_level_t'(`PKT_FIFO_DEPTH);

	pkt_data_t        mem [`PKT_FIFO_DEPTH]; // packet storage
	logic [PTR_W-1:0] wr_ptr;                // next free slot
	logic [PTR_W-1:0] rd_ptr;                // oldest packet
	pkt_level_t       count;                 // packets held
	logic             push_ok;               // push accepted
	logic             pop_ok;                // pop served

	assign full     = (count == DEPTH);
	assign nonempty = (count != '0);
	assign push_ok  = push && !full; // drop decision lives here only
	assign pop_ok   = pop && nonempty;

	assign head_packet = mem[rd_ptr];

	// advance with wrap, depth need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(`PKT_FIFO_DEPTH - 1)) begin
			return '0;
		end
		return ptr + PTR_W'(1);
	endfunction

	// storage write, no reset on payload
	always_ff @(posedge dataAvailable_in) begin
		if (push_ok) begin
			mem[wr_ptr] <= push_packet;
		end
	end

	always_ff @(posedge dataAvailable_in) begin
		if (reset) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			overflow <= push && full; // flag shows the cycle after the lost push
			if (push_ok) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop_ok) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			count <= count + pkt_level_t'(push_ok) - pkt_level_t'(pop_ok); // both may happen
		end
	end

	// dispatcher only reads a packet that is there
	a_no_pop_empty: assert property (
		@(posedge dataAvailable_in) disable iff (reset)
		pop |-> nonempty
	);

	a_count_bound: assert property (
		@(posedge dataAvailable_in) disable iff (reset)
		count <= DEPTH
	);

endmodule

// ==== packet_assembler/packet_assembler.sv ====
// packet assembler: byte shift register, byte index, first-to-last byte timeout, packet push
`include "pkt_cfg.svh"

module packet_assembler (
	input  logic               dataAvailable_in, // system clock
	input  logic               reset,            // sync, active high
	input  logic               byte_valid,       // one strobe per byte
	input  pkt_pkg::pkt_byte_t data_in,          // byte, valid with the strobe
	input  logic               fifo_full,        // buffer level, watched only
	output pkt_pkg::pkt_data_t packet,           // assembled packet, first byte on top
	output logic               packet_push,      // pulse the cycle after byte 16
	output logic               timeout           // pulse, partial packet dropped
);
	import pkt_pkg::*;

	localparam int         ELAPSED_W  = $clog2(`PKT_TIMEOUT_CYCLES + 1); // counts up to the limit
	localparam pkt_index_t LAST_INDEX = pkt_index_t'(`PKT_BYTES - 1);    // position of byte 16

	pkt_data_t            shift_reg;   // bytes shifted in msb first
	pkt_index_t           byte_index;  // next byte position
	logic                 in_progress; // a partial packet is open
	logic [ELAPSED_W-1:0] elapsed;     // cycles since the first byte
	logic                 expire;      // open packet ran out of time
	logic                 first_byte;  // strobe opens a new packet
	logic                 last_byte;   // strobe closes the open packet

	// window runs out at the edge where the counter hits the limit
	assign expire = in_progress && (elapsed == ELAPSED_W'(`PKT_TIMEOUT_CYCLES));

	// a byte arriving on expiry starts over as byte 0
	assign first_byte = byte_valid && (expire || !in_progress);
	assign last_byte  = byte_valid && !first_byte && (byte_index == LAST_INDEX);

	// payload shift, older bytes move toward the top
	always_ff @(posedge dataAvailable_in) begin
		if (byte_valid) begin
			shift_reg <= {shift_reg[`PKT_BITS-9:0], data_in}; // drop oldest byte, append new
		end
	end

	always_ff @(posedge dataAvailable_in) begin
		if (reset) begin
			byte_index  <= '0;
			in_progress <= 1'b0;
			elapsed     <= '0;
			packet_push <= 1'b0;
			timeout     <= 1'b0;
		end else begin
			packet_push <= last_byte; // one cycle latency after byte 16
			timeout     <= expire;    // single pulse, expire clears in_progress
			if (first_byte) begin
				byte_index  <= pkt_index_t'(1); // byte 0 taken, next is 1
				in_progress <= 1'b1;
				elapsed     <= ELAPSED_W'(1);   // count the first byte's cycle
			end else if (last_byte) begin
				byte_index  <= '0; // packet done
				in_progress <= 1'b0;
				elapsed     <= '0;
			end else if (expire) begin
				byte_index  <= '0; // abandon partial packet
				in_progress <= 1'b0;
				elapsed     <= '0;
			end else begin
				if (byte_valid) begin
					byte_index <= byte_index + pkt_index_t'(1); // middle byte
				end
				if (in_progress) begin
					elapsed <= elapsed + ELAPSED_W'(1); // keep timing the open packet
				end
			end
		end
	end

	assign packet = shift_reg; // full packet is stable while packet_push is high

	// a packet can't both finish and time out in one step
	a_push_timeout_excl: assert property (
		@(posedge dataAvailable_in) disable iff (reset)
		!(packet_push && timeout)
	);

	// pushes need sixteen strobes between them
	a_push_spacing: assert property (
		@(posedge dataAvailable_in) disable iff (reset)
		packet_push |=> !packet_push
	);

	// the buffer can only become full right after one of our pushes
	a_full_after_push: assert property (
		@(posedge dataAvailable_in) disable iff (reset)
		$rose(fifo_full) |-> $past(packet_push)
	);

endmodule

// ==== common/pkt_pkg.sv ====
// packet manager package: byte, packet, byte index and fifo level types
`include "pkt_cfg.svh"

package pkt_pkg;

	// one data byte as it arrives on data_in
	typedef logic [7:0] pkt_byte_t;

	// one full packet
	// first byte received sits in the top byte, checksum in the bottom byte
	typedef logic [`PKT_BITS-1:0] pkt_data_t;

	// byte position within a packet, 0 to 15
	typedef logic [3:0] pkt_index_t;

	// fifo occupancy, needs to reach the full depth so one extra code
	typedef logic [$clog2(`PKT_FIFO_DEPTH + 1)-1:0] pkt_level_t;

endpackage

// ==== common/pkt_cfg.svh ====
// packet manager configuration macros: packet size, timeout window, fifo depth
`ifndef PKT_CFG_SVH
`define PKT_CFG_SVH

// bytes per packet, one 128-bit word
`define PKT_BYTES 16

// packet width in bits, derived from the byte count
`define PKT_BITS (`PKT_BYTES * 8)

// max clock cycles allowed from first byte to last byte
`define PKT_TIMEOUT_CYCLES 64

// packets held by the buffer between assembler and dispatcher
`define PKT_FIFO_DEPTH 4

`endif
